//--- common/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// block RAM covers 0x0000 to 0x1FFF
`define RAM_ADDR_BITS 13

// PRNG at 0xFE00 to 0xFE0F
`define PRNG_PAGE 8'hFE

// timer at 0xFF00 to 0xFF0F
`define TIMER_PAGE 8'hFF

// LEDs at 0xFFF0 to 0xFFFF, same page as the timer
`define LEDS_PAGE 8'hFF

// Galois feedback mask, x^16 + x^14 + x^13 + x^11 + 1
`define LFSR_TAPS 16'hB400

// returned by the decoder for unmapped reads
`define UNMAPPED_DATA 8'hFF

`endif

//--- common/soc_pkg.sv
package soc_pkg;

    // decoded target of a bus cycle
    typedef enum logic [2:0] {
        REG_RAM   = 3'd0,
        REG_PRNG  = 3'd1,
        REG_TIMER = 3'd2,
        REG_LEDS  = 3'd3,
        REG_NONE  = 3'd4
    } region_e;

    // timer register offsets, adr[1:0]
    typedef enum logic [1:0] {
        TMR_RELOAD_LO = 2'd0,
        TMR_RELOAD_HI = 2'd1,
        // bit0 enable, bit1 clears the flag
        TMR_CTRL      = 2'd2,
        // bit0 flag
        TMR_STATUS    = 2'd3
    } timer_reg_e;

    // PRNG register offsets, adr[0]
    typedef enum logic {
        PRNG_DATA    = 1'b0,
        PRNG_SEED_HI = 1'b1
    } prng_reg_e;

endpackage

//--- common/wb8_if.sv
interface wb8_if;

    logic        stb;
    logic        we;
    logic [15:0] adr;
    logic [7:0]  dat_w;
    logic [7:0]  dat_r;
    logic        ack;

    // decoder side
    modport master (
        output stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // peripheral side
    modport slave (
        input  stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

//--- soc_top.f
+incdir+common
common/soc_pkg.sv
common/wb8_if.sv
src/bus_decoder.sv
src/bram_wb8.sv
src/prng_wb8.sv
src/timer_wb8.sv
src/leds_wb8.sv
src/soc_top.sv
tb/soc_checker.sv
tb/soc_tb.sv

//--- src/bram_wb8.sv
`include "soc_cfg.svh"

module bram_wb8 (
    input logic  clk,
    wb8_if.slave bus
);

    localparam int unsigned DEPTH = 1 << `RAM_ADDR_BITS;

    logic [7:0]                mem [0:DEPTH-1];
    logic [`RAM_ADDR_BITS-1:0] word_adr;
    logic [7:0]                dat_r_q;
    logic                      ack_q;
    logic                      cyc_start;

    assign word_adr  = bus.adr[`RAM_ADDR_BITS-1:0];
    // first cycle of a strobe, ack follows on the next edge
    assign cyc_start = bus.stb && !ack_q;

    // settles to 0 on the first edge with stb low
    always_ff @(posedge clk) begin
        ack_q <= cyc_start;
    end

    // registered read, write on the ack edge
    always_ff @(posedge clk) begin
        if (cyc_start) begin
            if (bus.we) begin
                mem[word_adr] <= bus.dat_w;
            end
            dat_r_q <= mem[word_adr];
        end
    end

    assign bus.dat_r = dat_r_q;
    assign bus.ack   = ack_q;

endmodule

//--- src/bus_decoder.sv
`include "soc_cfg.svh"

module bus_decoder (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [15:0] adr_i,
    input  logic [7:0]  dat_i,
    output logic [7:0]  dat_o,
    output logic        ack_o,
    wb8_if.master       ram_bus,
    wb8_if.master       prng_bus,
    wb8_if.master       timer_bus,
    wb8_if.master       leds_bus
);
    import soc_pkg::*;

    region_e region;
    logic    none_ack_q;

    // LED window is checked ahead of the timer page
    always_comb begin
        if (adr_i[15:`RAM_ADDR_BITS] == '0) begin
            region = REG_RAM;
        end else if (adr_i[15:8] == `LEDS_PAGE && adr_i[7:4] == 4'hF) begin
            region = REG_LEDS;
        end else if (adr_i[15:8] == `TIMER_PAGE && adr_i[7:4] == 4'h0) begin
            region = REG_TIMER;
        end else if (adr_i[15:8] == `PRNG_PAGE && adr_i[7:4] == 4'h0) begin
            region = REG_PRNG;
        end else begin
            region = REG_NONE;
        end
    end

    // shared cycle fields go to every slave
    assign ram_bus.adr     = adr_i;
    assign ram_bus.we      = we_i;
    assign ram_bus.dat_w   = dat_i;
    assign prng_bus.adr    = adr_i;
    assign prng_bus.we     = we_i;
    assign prng_bus.dat_w  = dat_i;
    assign timer_bus.adr   = adr_i;
    assign timer_bus.we    = we_i;
    assign timer_bus.dat_w = dat_i;
    assign leds_bus.adr    = adr_i;
    assign leds_bus.we     = we_i;
    assign leds_bus.dat_w  = dat_i;

    // strobe only the selected slave
    assign ram_bus.stb   = stb_i && (region == REG_RAM);
    assign prng_bus.stb  = stb_i && (region == REG_PRNG);
    assign timer_bus.stb = stb_i && (region == REG_TIMER);
    assign leds_bus.stb  = stb_i && (region == REG_LEDS);

    // default responder so stray cycles still complete
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= stb_i && (region == REG_NONE) && !none_ack_q;
        end
    end

    always_comb begin
        case (region)
            REG_RAM: begin
                dat_o = ram_bus.dat_r;
                ack_o = ram_bus.ack;
            end
            REG_PRNG: begin
                dat_o = prng_bus.dat_r;
                ack_o = prng_bus.ack;
            end
            REG_TIMER: begin
                dat_o = timer_bus.dat_r;
                ack_o = timer_bus.ack;
            end
            REG_LEDS: begin
                dat_o = leds_bus.dat_r;
                ack_o = leds_bus.ack;
            end
            default: begin
                dat_o = `UNMAPPED_DATA;
                ack_o = none_ack_q;
            end
        endcase
    end

endmodule

//--- src/leds_wb8.sv
module leds_wb8 (
    input  logic       clk,
    input  logic       rst_n_i,
    wb8_if.slave       bus,
    output logic [7:0] leds_o
);

    logic [7:0] leds_q;
    logic       ack_q;
    logic       cyc_start;

    assign cyc_start = bus.stb && !ack_q;

    // any offset in the window hits the same register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            leds_q <= 8'h00;
        end else begin
            ack_q <= cyc_start;
            if (cyc_start && bus.we) begin
                leds_q <= bus.dat_w;
            end
        end
    end

    // readback straight from the register
    assign bus.dat_r = leds_q;
    assign bus.ack   = ack_q;
    assign leds_o    = leds_q;

endmodule

//--- src/prng_wb8.sv
`include "soc_cfg.svh"

module prng_wb8 (
    input logic  clk,
    input logic  rst_n_i,
    wb8_if.slave bus
);
    import soc_pkg::*;

    prng_reg_e   reg_sel;
    logic [15:0] state_q;
    logic [15:0] state_next;
    logic [7:0]  dat_r_q;
    logic        ack_q;
    logic        cyc_start;

    assign reg_sel   = prng_reg_e'(bus.adr[0]);
    assign cyc_start = bus.stb && !ack_q;

    // Galois step, shift right and fold in taps on a shifted-out one
    assign state_next = (state_q >> 1) ^ (state_q[0] ? `LFSR_TAPS : 16'h0000);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            state_q <= 16'h0001;
        end else begin
            ack_q <= cyc_start;
            if (cyc_start) begin
                if (bus.we) begin
                    if (reg_sel == PRNG_DATA) begin
                        state_q[7:0] <= bus.dat_w;
                    end else begin
                        state_q[15:8] <= bus.dat_w;
                    end
                end else if (reg_sel == PRNG_DATA) begin
                    // only a data read advances the sequence
                    state_q <= state_next;
                end
            end
        end
    end

    // sample before the step so the current byte is returned
    always_ff @(posedge clk) begin
        if (cyc_start) begin
            dat_r_q <= (reg_sel == PRNG_DATA) ? state_q[7:0] : state_q[15:8];
        end
    end

    assign bus.dat_r = dat_r_q;
    assign bus.ack   = ack_q;

endmodule

//--- src/soc_top.sv
module soc_top (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [15:0] wb_adr_i,
    input  logic [7:0]  wb_dat_i,
    output logic [7:0]  wb_dat_o,
    output logic        wb_ack_o,
    output logic [7:0]  leds_o,
    output logic        irq_o
);

    // one bus per slave, driven by the decoder
    wb8_if ram_bus ();
    wb8_if prng_bus ();
    wb8_if timer_bus ();
    wb8_if leds_bus ();

    bus_decoder u_decoder (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .stb_i     (wb_stb_i),
        .we_i      (wb_we_i),
        .adr_i     (wb_adr_i),
        .dat_i     (wb_dat_i),
        .dat_o     (wb_dat_o),
        .ack_o     (wb_ack_o),
        .ram_bus   (ram_bus),
        .prng_bus  (prng_bus),
        .timer_bus (timer_bus),
        .leds_bus  (leds_bus)
    );

    bram_wb8 u_bram (
        .clk (clk),
        .bus (ram_bus)
    );

    prng_wb8 u_prng (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (prng_bus)
    );

    timer_wb8 u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (timer_bus),
        .irq_o   (irq_o)
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (leds_bus),
        .leds_o  (leds_o)
    );

endmodule

//--- src/timer_wb8.sv
module timer_wb8 (
    input  logic clk,
    input  logic rst_n_i,
    wb8_if.slave bus,
    output logic irq_o
);
    import soc_pkg::*;

    timer_reg_e  reg_sel;
    logic [15:0] reload_q;
    logic [15:0] count_q;
    logic        enable_q;
    logic        flag_q;
    logic [7:0]  dat_r_q;
    logic        ack_q;
    logic        cyc_start;
    logic        wr_en;
    logic        hit;

    assign reg_sel   = timer_reg_e'(bus.adr[1:0]);
    assign cyc_start = bus.stb && !ack_q;
    assign wr_en     = cyc_start && bus.we;
    // counter expires on this edge
    assign hit       = enable_q && (count_q == 16'd0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            reload_q <= 16'd0;
            count_q  <= 16'd0;
            enable_q <= 1'b0;
            flag_q   <= 1'b0;
        end else begin
            ack_q <= cyc_start;
            if (hit) begin
                count_q <= reload_q;
                flag_q  <= 1'b1;
            end else if (enable_q) begin
                count_q <= count_q - 16'd1;
            end
            // bus writes override the countdown
            if (wr_en) begin
                case (reg_sel)
                    TMR_RELOAD_LO: reload_q[7:0] <= bus.dat_w;
                    TMR_RELOAD_HI: reload_q[15:8] <= bus.dat_w;
                    TMR_CTRL: begin
                        enable_q <= bus.dat_w[0];
                        if (bus.dat_w[0]) begin
                            count_q <= reload_q;
                        end
                        // an expiry on the same edge is not lost
                        if (bus.dat_w[1] && !hit) begin
                            flag_q <= 1'b0;
                        end
                    end
                    default: begin
                        // status is read only
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cyc_start) begin
            case (reg_sel)
                TMR_RELOAD_LO: dat_r_q <= reload_q[7:0];
                TMR_RELOAD_HI: dat_r_q <= reload_q[15:8];
                TMR_CTRL:      dat_r_q <= {7'd0, enable_q};
                default:       dat_r_q <= {7'd0, flag_q};
            endcase
        end
    end

    assign bus.dat_r = dat_r_q;
    assign bus.ack   = ack_q;
    assign irq_o     = flag_q;

endmodule

//--- tb/soc_checker.sv
`include "soc_cfg.svh"

module soc_checker (
    input logic        clk,
    input logic        rst_n_i,
    input logic        stb_i,
    input logic        we_i,
    input logic [15:0] adr_i,
    input logic [7:0]  dat_i,
    input logic        ack_i,
    input logic        irq_i
);
    import soc_pkg::*;

    logic enabled_seen;
    int   assert_errors = 0;

    // any write to timer CTRL with the enable bit set
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            enabled_seen <= 1'b0;
        end else if (stb_i && we_i && dat_i[0] && adr_i[15:8] == `TIMER_PAGE
                     && adr_i[7:4] == 4'h0 && adr_i[1:0] == TMR_CTRL) begin
            enabled_seen <= 1'b1;
        end
    end

    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(stb_i))
    else begin
        $error("ack rose without a strobe in the previous cycle");
        assert_errors++;
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
    else begin
        $error("ack stayed high for two cycles");
        assert_errors++;
    end

    // interrupt needs the timer to have been enabled at some point
    irq_needs_enable: assert property (@(posedge clk) disable iff (!rst_n_i)
        irq_i |-> enabled_seen)
    else begin
        $error("irq high although the timer was never enabled");
        assert_errors++;
    end

endmodule

bind soc_top soc_checker u_checker (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stb_i   (wb_stb_i),
    .we_i    (wb_we_i),
    .adr_i   (wb_adr_i),
    .dat_i   (wb_dat_i),
    .ack_i   (wb_ack_o),
    .irq_i   (irq_o)
);

//--- tb/soc_tb.sv
`include "soc_cfg.svh"

module soc_tb;
    import soc_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RAM_OPS    = 40;
    localparam int ROUNDS     = 6;
    localparam int PRNG_READS = 4;
    localparam int MAX_RELOAD = 16;
    // writes, reads and rereads of RAM plus the per-round cycles of the other tests
    localparam int NUM_TRANSACTIONS = 3 * RAM_OPS + ROUNDS * (PRNG_READS + 17) + 1;
    localparam int WATCHDOG_CYCLES  = NUM_TRANSACTIONS * 4 + ROUNDS * (MAX_RELOAD + 1) + 100;

    logic        clk;
    logic        rst_n_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [15:0] wb_adr_i;
    logic [7:0]  wb_dat_i;
    logic [7:0]  wb_dat_o;
    logic        wb_ack_o;
    logic [7:0]  leds_o;
    logic        irq_o;

    logic [31:0] lcg_state = 32'h0741_2df4;
    logic [7:0]  ram_shadow [0:(1 << `RAM_ADDR_BITS) - 1];
    bit          ram_valid [0:(1 << `RAM_ADDR_BITS) - 1];
    logic [15:0] written_q [$];
    logic [7:0]  leds_model;
    logic [15:0] lfsr_model;
    logic        irq_at_ack;
    logic [7:0]  leds_at_ack;
    int          mismatches;
    int          failures;

    soc_top dut_i (.*);

    // upper half of the LCG state since the low bits repeat too quickly
    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] shifted;
        shifted = s >> 1;
        if (s[0]) begin
            shifted = shifted ^ `LFSR_TAPS;
        end
        return shifted;
    endfunction

    // address map with the LED window ahead of the timer page
    function automatic region_e region_of(input logic [15:0] adr);
        if (adr < (16'h1 << `RAM_ADDR_BITS)) return REG_RAM;
        if (adr[15:8] == `LEDS_PAGE && adr[7:4] == 4'hF) return REG_LEDS;
        if (adr[15:8] == `TIMER_PAGE && adr[7:4] == 4'h0) return REG_TIMER;
        if (adr[15:8] == `PRNG_PAGE && adr[7:4] == 4'h0) return REG_PRNG;
        return REG_NONE;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        mismatches++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        failures++;
    endtask

    // entered and left 2 units after a rising edge
    task automatic bus_access(input logic we, input logic [15:0] adr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        @(posedge clk);
        #2;
        if (wb_ack_o !== 1'b1) begin
            report_failure($sformatf("no ack one cycle after the strobe to %h", adr));
        end
        rdata       = wb_dat_o;
        irq_at_ack  = irq_o;
        leds_at_ack = leds_o;
        wb_stb_i    = 1'b0;
        @(posedge clk);
        #2;
        if (wb_ack_o !== 1'b0) begin
            report_failure($sformatf("ack from %h held longer than one cycle", adr));
        end
    endtask

    task automatic bus_write(input logic [15:0] adr, input logic [7:0] data);
        logic [7:0] ignored;
        bus_access(1'b1, adr, data, ignored);
    endtask

    task automatic expect_read(input logic [15:0] adr, input logic [7:0] exp);
        logic [7:0] data;
        bus_access(1'b0, adr, 8'h00, data);
        if (data !== exp) begin
            report_mismatch("wb_dat_o", exp, data);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error: run timed out at %0t", $time);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [15:0] adr;
        logic [7:0]  data;
        int          reload;
        int          cycles;
        rst_n_i    = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = 16'h0000;
        wb_dat_i   = 8'h00;
        mismatches = 0;
        failures   = 0;
        leds_model = 8'h00;
        lfsr_model = 16'h0001;
        repeat (3) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        if (wb_ack_o !== 1'b0) report_mismatch("wb_ack_o", 16'h0, wb_ack_o);
        if (irq_o !== 1'b0) report_mismatch("irq_o", 16'h0, irq_o);
        if (leds_o !== 8'h00) report_mismatch("leds_o", 16'h0, leds_o);

        // RAM writes, then reads with half of them on written bytes
        for (int i = 0; i < RAM_OPS; i++) begin
            adr  = rand16() % (1 << `RAM_ADDR_BITS);
            data = 8'(rand16());
            bus_write(adr, data);
            ram_shadow[adr] = data;
            ram_valid[adr]  = 1'b1;
            written_q.push_back(adr);
        end
        for (int i = 0; i < RAM_OPS; i++) begin
            if (rand16() % 2 == 0) begin
                adr = written_q[rand16() % written_q.size()];
            end else begin
                adr = rand16() % (1 << `RAM_ADDR_BITS);
            end
            bus_access(1'b0, adr, 8'h00, data);
            if (ram_valid[adr] && data !== ram_shadow[adr]) begin
                report_mismatch("wb_dat_o", ram_shadow[adr], data);
            end
        end

        // LED register at any offset in the window
        for (int i = 0; i < ROUNDS; i++) begin
            data = 8'(rand16());
            bus_write({`LEDS_PAGE, 4'hF, 4'(rand16())}, data);
            leds_model = data;
            if (leds_at_ack !== leds_model) report_mismatch("leds_o", leds_model, leds_at_ack);
            expect_read({`LEDS_PAGE, 4'hF, 4'(rand16())}, leds_model);
        end

        // PRNG from its reset state, then from random seeds
        expect_read({`PRNG_PAGE, 7'd0, PRNG_DATA}, lfsr_model[7:0]);
        lfsr_model = lfsr_step(lfsr_model);
        for (int i = 0; i < ROUNDS; i++) begin
            data = 8'(rand16());
            bus_write({`PRNG_PAGE, 7'd0, PRNG_DATA}, data);
            lfsr_model[7:0] = data;
            data = 8'(rand16());
            bus_write({`PRNG_PAGE, 7'd0, PRNG_SEED_HI}, data);
            lfsr_model[15:8] = data;
            for (int j = 0; j < PRNG_READS; j++) begin
                expect_read({`PRNG_PAGE, 4'h0, 3'(rand16()), PRNG_DATA}, lfsr_model[7:0]);
                lfsr_model = lfsr_step(lfsr_model);
            end
            // high byte read does not step
            expect_read({`PRNG_PAGE, 7'd0, PRNG_SEED_HI}, lfsr_model[15:8]);
            expect_read({`PRNG_PAGE, 7'd0, PRNG_DATA}, lfsr_model[7:0]);
            lfsr_model = lfsr_step(lfsr_model);
        end

        // timer expiry exactly reload+1 cycles after the enabling ack
        for (int i = 0; i < ROUNDS; i++) begin
            reload = 1 + rand16() % MAX_RELOAD;
            bus_write({`TIMER_PAGE, 6'd0, TMR_RELOAD_LO}, 8'(reload));
            bus_write({`TIMER_PAGE, 6'd0, TMR_RELOAD_HI}, 8'h00);
            if (irq_o !== 1'b0) report_mismatch("irq_o", 16'h0, irq_o);
            bus_write({`TIMER_PAGE, 6'd0, TMR_CTRL}, 8'h01);
            // bus_write returns one cycle after its ack
            cycles = 1;
            while (cycles <= reload) begin
                if (irq_o !== 1'b0) report_mismatch("irq_o", 16'h0, irq_o);
                @(posedge clk);
                #2;
                cycles++;
            end
            if (irq_o !== 1'b1) report_mismatch("irq_o", 16'h1, irq_o);
            expect_read({`TIMER_PAGE, 6'd0, TMR_STATUS}, 8'h01);
            expect_read({`TIMER_PAGE, 6'd0, TMR_RELOAD_LO}, 8'(reload));
            expect_read({`TIMER_PAGE, 6'd0, TMR_CTRL}, 8'h01);
            bus_write({`TIMER_PAGE, 6'd0, TMR_CTRL}, 8'h00);
            bus_write({`TIMER_PAGE, 6'd0, TMR_CTRL}, 8'h02);
            if (irq_at_ack !== 1'b0) report_mismatch("irq_o", 16'h0, irq_at_ack);
            expect_read({`TIMER_PAGE, 6'd0, TMR_STATUS}, 8'h00);
        end

        // unmapped cycles complete and change nothing
        for (int i = 0; i < ROUNDS; i++) begin
            adr = rand16();
            while (region_of(adr) != REG_NONE) begin
                adr = rand16();
            end
            expect_read(adr, `UNMAPPED_DATA);
            bus_write(adr, 8'(rand16()));
            if (leds_at_ack !== leds_model) report_mismatch("leds_o", leds_model, leds_at_ack);
        end
        foreach (written_q[i]) begin
            expect_read(written_q[i], ram_shadow[written_q[i]]);
        end

        $display("checks done: %0d mismatches, %0d other errors, %0d assertion errors",
                 mismatches, failures, dut_i.u_checker.assert_errors);
        if (mismatches + failures + dut_i.u_checker.assert_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
